// File: src/wb_ram_defines.svh
// widths and depth are fixed at elaboration; bus addresses are word addresses, not byte
`ifndef WB_RAM_DEFINES_SVH
`define WB_RAM_DEFINES_SVH

// data path
`define WB_RAM_DW       32
`define WB_RAM_SELW     (`WB_RAM_DW / 8)

// memory words, 1024 deep
`define WB_RAM_AW       10
`define WB_RAM_DEPTH    (1 << `WB_RAM_AW)

// bus word address, wider than the memory so range errors can be raised
`define WB_BUS_AW       12

// cycle type codes, only classic and incrementing bursts are decoded
`define WB_CTI_CLASSIC  3'b000
`define WB_CTI_INCR     3'b010
`define WB_CTI_END      3'b111

`endif

// File: src/wb_ram_pkg.sv
// shared types only; debug writes are always full words, so dbg_req_t carries no select
`include "wb_ram_defines.svh"

package wb_ram_pkg;

    typedef logic [`WB_RAM_DW-1:0]   word_t;
    typedef logic [`WB_RAM_SELW-1:0] sel_t;
    typedef logic [`WB_BUS_AW-1:0]   bus_addr_t;
    typedef logic [`WB_RAM_AW-1:0]   ram_addr_t;
    typedef logic [2:0]              cti_t;

    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        bus_addr_t addr;
        sel_t      sel;
        word_t     dat;
        cti_t      cti;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        logic  err;
        word_t dat;
    } wb_rsp_t;

    // one access on the single memory port
    typedef struct packed {
        logic      en;
        logic      we;
        ram_addr_t addr;
        sel_t      sel;
        word_t     wdata;
    } ram_req_t;

    typedef struct packed {
        logic      req;
        logic      we;
        ram_addr_t addr;
        word_t     wdata;
    } dbg_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } dbg_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        BURST,
        RESP  // response cycle, stb ignored
    } ctrl_state_t;

endpackage

// File: src/byte_en_ram.sv
// no reset and no init file, contents are undefined until written; read-during-write gives old data
`include "wb_ram_defines.svh"

module byte_en_ram (
    input  logic                 clk,
    input  wb_ram_pkg::ram_req_t ram_req_i,
    output wb_ram_pkg::word_t    rdata_o
);

    wb_ram_pkg::word_t mem [`WB_RAM_DEPTH];
    wb_ram_pkg::word_t rdata_q;

    always_ff @(posedge clk) begin
        if (ram_req_i.en) begin
            if (ram_req_i.we) begin
                for (int b = 0; b < `WB_RAM_SELW; b++) begin
                    if (ram_req_i.sel[b]) begin
                        mem[ram_req_i.addr][8*b +: 8] <= ram_req_i.wdata[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[ram_req_i.addr];  // old word on a same-address write
        end
    end

    assign rdata_o = rdata_q;  // holds between accesses

    // zero select would be an ack'ed write that changes nothing
    a_write_sel: assert property (
        @(posedge clk)
        (ram_req_i.en && ram_req_i.we) |-> (ram_req_i.sel != '0)
    ) else $error("memory write with no byte selected");

endmodule

// File: src/ram_port_arbiter.sv
// fixed priority, bus first; a debug request can starve for the length of a bus burst
`include "wb_ram_defines.svh"

module ram_port_arbiter (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  wb_ram_pkg::ram_req_t bus_req_i,
    input  wb_ram_pkg::dbg_req_t dbg_req_i,
    output wb_ram_pkg::dbg_rsp_t dbg_rsp_o,
    output wb_ram_pkg::ram_req_t ram_req_o,
    input  wb_ram_pkg::word_t    ram_rdata_i
);

    logic                 dbg_gnt;
    logic                 dbg_gnt_q;    // debug access in flight
    wb_ram_pkg::ram_req_t dbg_ram_req;

    // req is still high during its ack cycle, mask it so it is served once
    assign dbg_gnt = dbg_req_i.req && !bus_req_i.en && !dbg_gnt_q;

    always_comb begin
        dbg_ram_req.en    = dbg_gnt;
        dbg_ram_req.we    = dbg_gnt && dbg_req_i.we;
        dbg_ram_req.addr  = dbg_req_i.addr;
        dbg_ram_req.sel   = {`WB_RAM_SELW{1'b1}};  // whole word
        dbg_ram_req.wdata = dbg_req_i.wdata;
    end

    assign ram_req_o = bus_req_i.en ? bus_req_i : dbg_ram_req;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dbg_gnt_q <= 1'b0;
        end else begin
            dbg_gnt_q <= dbg_gnt;
        end
    end

    // memory read latency is one cycle, same as the ack
    always_comb begin
        dbg_rsp_o.ack   = dbg_gnt_q;
        dbg_rsp_o.rdata = ram_rdata_i;
    end

    // a debug ack must trace back to a memory cycle the bus did not own
    a_dbg_ack_granted: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        dbg_rsp_o.ack |-> $past(ram_req_o.en && !bus_req_i.en && dbg_req_i.req)
    ) else $error("debug ack without a debug grant");

endmodule

// File: src/wb_bram_ctrl.sv
// classic and incrementing bursts only; no bte, tags or retry; rsp dat valid only with ack
`include "wb_ram_defines.svh"

module wb_bram_ctrl (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  wb_ram_pkg::wb_req_t  wb_req_i,
    output wb_ram_pkg::wb_rsp_t  wb_rsp_o,
    output wb_ram_pkg::ram_req_t ram_req_o,
    input  wb_ram_pkg::word_t    ram_rdata_i
);

    wb_ram_pkg::ctrl_state_t state_q;
    wb_ram_pkg::ctrl_state_t state_d;
    wb_ram_pkg::bus_addr_t   burst_addr_q;  // next burst word
    wb_ram_pkg::bus_addr_t   cur_addr;
    logic                    beat;
    logic                    in_range;
    logic                    incr;
    logic                    ack_q;
    logic                    err_q;

    // first beat takes the master's address, later beats the local counter
    assign cur_addr = (state_q == wb_ram_pkg::BURST) ? burst_addr_q : wb_req_i.addr;
    assign in_range = cur_addr < wb_ram_pkg::bus_addr_t'(`WB_RAM_DEPTH);
    assign incr     = wb_req_i.cti == `WB_CTI_INCR;

    // a beat is taken in any cycle with cyc and stb, except the response cycle
    assign beat = wb_req_i.cyc && wb_req_i.stb && (state_q != wb_ram_pkg::RESP);

    always_comb begin
        state_d = state_q;
        case (state_q)
            wb_ram_pkg::IDLE: begin
                if (beat) begin
                    state_d = (incr && in_range) ? wb_ram_pkg::BURST : wb_ram_pkg::RESP;
                end
            end
            wb_ram_pkg::BURST: begin
                if (!wb_req_i.cyc) begin
                    state_d = wb_ram_pkg::IDLE;  // master abandoned the burst
                end else if (beat && (!incr || !in_range)) begin
                    state_d = wb_ram_pkg::RESP;  // last beat, or ran off the end
                end
            end
            wb_ram_pkg::RESP: state_d = wb_ram_pkg::IDLE;
            default:          state_d = wb_ram_pkg::IDLE;
        endcase
    end

    // memory access goes out in the same cycle the beat is seen
    always_comb begin
        ram_req_o.en    = beat && in_range;
        ram_req_o.we    = beat && in_range && wb_req_i.we;
        ram_req_o.addr  = cur_addr[`WB_RAM_AW-1:0];
        ram_req_o.sel   = wb_req_i.sel;
        ram_req_o.wdata = wb_req_i.dat;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= wb_ram_pkg::IDLE;
            burst_addr_q <= '0;
            ack_q        <= 1'b0;
            err_q        <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_q   <= beat && in_range;
            err_q   <= beat && !in_range;
            if (beat && in_range) begin
                burst_addr_q <= cur_addr + 1'b1;  // held while stb is low
            end
        end
    end

    // read data comes straight off the registered memory output
    always_comb begin
        wb_rsp_o.ack = ack_q;
        wb_rsp_o.err = err_q;
        wb_rsp_o.dat = ram_rdata_i;
    end

    a_ack_err_excl: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wb_rsp_o.ack |-> !wb_rsp_o.err
    ) else $error("ack and err high together");

    // an error response must not have touched the memory the cycle before
    a_err_no_access: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wb_rsp_o.err |-> $past(!ram_req_o.en)
    ) else $error("memory accessed for an out-of-range address");

endmodule

// File: src/wb_ram_top.sv
// one memory port shared by bus and debug; bus always wins, so debug can wait through a burst
`include "wb_ram_defines.svh"

module wb_ram_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  wb_ram_pkg::wb_req_t  wb_req_i,
    output wb_ram_pkg::wb_rsp_t  wb_rsp_o,
    input  wb_ram_pkg::dbg_req_t dbg_req_i,
    output wb_ram_pkg::dbg_rsp_t dbg_rsp_o
);

    wb_ram_pkg::ram_req_t bus_ram_req;  // from bus controller
    wb_ram_pkg::ram_req_t mem_req;      // after arbitration
    wb_ram_pkg::word_t    mem_rdata;

    // bus slave, input side and ack/err return path
    wb_bram_ctrl u_ctrl (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .ram_req_o   (bus_ram_req),
        .ram_rdata_i (mem_rdata)
    );

    ram_port_arbiter u_arb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus_req_i   (bus_ram_req),
        .dbg_req_i   (dbg_req_i),
        .dbg_rsp_o   (dbg_rsp_o),
        .ram_req_o   (mem_req),
        .ram_rdata_i (mem_rdata)
    );

    // read data fans out to both requesters
    byte_en_ram u_ram (
        .clk       (clk),
        .ram_req_i (mem_req),
        .rdata_o   (mem_rdata)
    );

endmodule

// File: test/tb_clk_gen.sv
// free-running clock from time zero; reset is released on a falling edge after RST_CYCLES
module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;  // away from the sampling edge
    end
endmodule

// File: test/tb_wb_ram.sv
// needs test/wb_ram_input.txt relative to the run directory; bursts read back base + beat index
`include "wb_ram_defines.svh"

module tb_wb_ram;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLES_PER_LINE = 40;
    localparam int ACK_LIMIT       = 64;  // edges to wait for any response

    logic                 clk;
    logic                 arst_n_i;
    wb_ram_pkg::wb_req_t  wb_req;
    wb_ram_pkg::wb_rsp_t  wb_rsp;
    wb_ram_pkg::dbg_req_t dbg_req;
    wb_ram_pkg::dbg_rsp_t dbg_rsp;

    string       op_q[$];
    string       name_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] sel_q[$];  // burst length for brd and bdrd
    logic [31:0] data_q[$];
    logic [31:0] exp_q[$];
    int          n_lines = 0;
    bit          loaded  = 1'b0;
    int          errs    = 0;
    int          checks  = 0;
    int          seed    = 32'h8570;

    tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(5)) u_clk_gen (.clk_o(clk), .arst_n_o(arst_n_i));

    wb_ram_top u_dut (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .dbg_req_i (dbg_req),
        .dbg_rsp_o (dbg_rsp)
    );

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errs++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errs++;
            $display("%s: %s", name, what);
        end
    endtask

    task automatic load_file();
        int               fd;
        int               cnt;
        logic [8*128-1:0] line_v;
        logic [8*8-1:0]   op_v;
        logic [8*32-1:0]  name_v;
        logic [31:0]      f_addr;
        logic [31:0]      f_sel;
        logic [31:0]      f_data;
        logic [31:0]      f_exp;
        string            op_s;
        fd = $fopen("test/wb_ram_input.txt", "r");
        check_flag("load", fd != 0, "cannot open test/wb_ram_input.txt");
        if (fd != 0) begin
            while ($fgets(line_v, fd) != 0) begin
                n_lines++;
                op_v = '0;
                cnt  = $sscanf(line_v, "%s %s %h %h %h %h", op_v, name_v, f_addr, f_sel,
                               f_data, f_exp);
                op_s = string'(op_v);
                if (cnt > 0 && op_s.getc(0) != "#") begin  // skip blanks and column notes
                    check_flag("load", cnt == 6, $sformatf("short line %0d in input", n_lines));
                    if (cnt == 6) begin
                        op_q.push_back(op_s);
                        name_q.push_back(string'(name_v));
                        addr_q.push_back(f_addr);
                        sel_q.push_back(f_sel);
                        data_q.push_back(f_data);
                        exp_q.push_back(f_exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // classic cycle, request held until ack or err
    task automatic bus_single(input logic we, input wb_ram_pkg::bus_addr_t addr,
                              input wb_ram_pkg::sel_t sel, input wb_ram_pkg::word_t dat,
                              output logic ack, output logic err,
                              output wb_ram_pkg::word_t rdata, output int lat);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, sel: sel, dat: dat,
                    cti: `WB_CTI_CLASSIC};
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!wb_rsp.ack && !wb_rsp.err && lat < ACK_LIMIT);
        ack   = wb_rsp.ack;
        err   = wb_rsp.err;
        rdata = wb_rsp.dat;
        wb_req <= '0;
    endtask

    task automatic burst_read(input string name, input wb_ram_pkg::bus_addr_t addr,
                              input int len, input wb_ram_pkg::word_t base,
                              output time last_ack_t);
        int n_ack;
        bit want;
        n_ack      = 0;
        last_ack_t = 0;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, addr: addr, sel: '1, dat: '0,
                    cti: (len == 1) ? `WB_CTI_END : `WB_CTI_INCR};
        for (int e = 1; e <= len + 3; e++) begin
            @(posedge clk);
            want = (e >= 2) && (e <= len + 1);  // beat k acked in the cycle after it
            check_flag(name, (wb_rsp.ack == want) && !wb_rsp.err,
                       $sformatf("wrong ack/err level in burst cycle %0d", e));
            if (wb_rsp.ack) begin
                check_value(name, base + n_ack, wb_rsp.dat);
                n_ack++;
                last_ack_t = $time;
            end
            if (e == len - 1) wb_req.cti <= `WB_CTI_END;
            if (e == len) wb_req <= '0;
        end
        check_value({name, "_acks"}, len, n_ack);
    endtask

    task automatic dbg_access(input logic we, input wb_ram_pkg::ram_addr_t addr,
                              input wb_ram_pkg::word_t wdata, output logic ack,
                              output wb_ram_pkg::word_t rdata, output time ack_t);
        int n;
        n = 0;
        @(posedge clk);
        dbg_req <= '{req: 1'b1, we: we, addr: addr, wdata: wdata};
        do begin
            @(posedge clk);
            n++;
        end while (!dbg_rsp.ack && n < ACK_LIMIT);
        ack   = dbg_rsp.ack;
        rdata = dbg_rsp.rdata;
        ack_t = $time;
        dbg_req <= '0;
    endtask

    task automatic run_line(input int i);
        logic              ack;
        logic              err;
        logic              dack;
        wb_ram_pkg::word_t rdata;
        wb_ram_pkg::word_t drdata;
        int                lat;
        time               bus_t;
        time               dbg_t;
        string             nm;
        nm = name_q[i];
        case (op_q[i])
            "wr", "rd": begin
                bus_single(op_q[i] == "wr", wb_ram_pkg::bus_addr_t'(addr_q[i]),
                           wb_ram_pkg::sel_t'(sel_q[i]), data_q[i], ack, err, rdata, lat);
                check_value({nm, "_latency"}, 2, lat);  // seen at N+1, answered at N+2
                if (addr_q[i] >= 32'(`WB_RAM_DEPTH)) begin
                    check_flag(nm, err && !ack, "out-of-range access not answered by err alone");
                end else begin
                    check_flag(nm, ack && !err, "no ack from the bus slave");
                    if (op_q[i] == "rd") check_value(nm, exp_q[i], rdata);
                end
            end
            "brd": burst_read(nm, wb_ram_pkg::bus_addr_t'(addr_q[i]), int'(sel_q[i]),
                              exp_q[i], bus_t);
            "dwr", "drd": begin
                dbg_access(op_q[i] == "dwr", wb_ram_pkg::ram_addr_t'(addr_q[i]), data_q[i],
                           dack, drdata, dbg_t);
                check_flag(nm, dack, "no ack on the debug port");
                if (op_q[i] == "drd") check_value(nm, exp_q[i], drdata);
            end
            "bdrd": begin
                fork
                    burst_read(nm, wb_ram_pkg::bus_addr_t'(addr_q[i]), int'(sel_q[i]),
                               exp_q[i], bus_t);
                    begin
                        @(posedge clk);  // raise debug once the burst is under way
                        dbg_access(1'b0, wb_ram_pkg::ram_addr_t'(data_q[i]), '0, dack, drdata,
                                   dbg_t);
                    end
                join
                check_flag(nm, dack, "no ack on the debug port");
                check_flag(nm, dbg_t > bus_t, "debug ack came before the last burst ack");
                check_value({nm, "_dbg"}, exp_q[i] + (data_q[i] - addr_q[i]), drdata);
            end
            default: check_flag(nm, 1'b0, $sformatf("unknown operation %s", op_q[i]));
        endcase
    endtask

    initial begin
        wb_req  <= '0;
        dbg_req <= '0;
        load_file();
        loaded = 1'b1;
        wait (arst_n_i);
        @(posedge clk);
        check_flag("reset", !wb_rsp.ack && !wb_rsp.err && !dbg_rsp.ack,
                   "response flags not low after reset");
        for (int i = 0; i < op_q.size(); i++) begin
            repeat ($unsigned($random(seed)) % 4) @(posedge clk);  // idle gap 0..3
            run_line(i);
        end
        repeat (2) @(posedge clk);
        $display("%0d error(s) in %0d checks", errs, checks);
        if (errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog, budget grows with the input length
    initial begin
        wait (loaded);
        repeat (n_lines * CYCLES_PER_LINE) @(posedge clk);
        errs++;
        $display("watchdog: run not finished after %0d cycles", n_lines * CYCLES_PER_LINE);
        $display("%0d error(s) in %0d checks", errs, checks);
        $display("Errors found");
        $finish;
    end
endmodule

// File: wb_ram.f
+incdir+src
src/wb_ram_pkg.sv
src/byte_en_ram.sv
src/ram_port_arbiter.sv
src/wb_bram_ctrl.sv
src/wb_ram_top.sv
test/tb_clk_gen.sv
test/tb_wb_ram.sv

// File: Makefile
# Verilator build of the wb_ram testbench, run from the project root
VERILATOR ?= verilator
TOP       ?= tb_wb_ram
FILELIST  ?= wb_ram.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j $(JOBS)
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/wb_ram_input.txt
# columns: op name addr sel data expected, all hex; ops wr rd brd dwr drd bdrd
# brd/bdrd: sel = burst length, expected = first word; bdrd data = debug read address
wr   wr_full     010 f 12345678 00000000
rd   rd_full     010 f 00000000 12345678
wr   wr_base     011 f aabbccdd 00000000
wr   wr_part     011 5 11223344 00000000
rd   rd_part     011 f 00000000 aa22cc44
wr   wr_hi_byte  011 8 ee000000 00000000
rd   rd_hi_byte  011 f 00000000 ee22cc44
wr   wr_keep     020 f cafef00d 00000000
wr   wr_oor      420 f deadbeef 00000000
rd   rd_oor      7ff f 00000000 00000000
rd   rd_keep     020 f 00000000 cafef00d
wr   burst_w0    100 f 50000000 00000000
wr   burst_w1    101 f 50000001 00000000
wr   burst_w2    102 f 50000002 00000000
wr   burst_w3    103 f 50000003 00000000
wr   burst_w4    104 f 50000004 00000000
brd  burst_rd4   100 4 00000000 50000000
brd  burst_rd1   104 1 00000000 50000004
dwr  dbg_wr      030 f 0badc0de 00000000
rd   rd_dbg_wr   030 f 00000000 0badc0de
wr   bus_wr      031 f 600dcafe 00000000
drd  dbg_rd_bus  031 f 00000000 600dcafe
bdrd burst_dbg   100 4 00000102 50000000
